// File: Makefile
TOP  := lsu_tb
SRCS := $(filter-out +%,$(shell cat vlog.f))

all: run

obj_dir/V$(TOP): vlog.f $(SRCS) design/lsu_params.svh
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: design/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module data_ram (
  input  logic clk,
  input  logic rst,
  wb_if.slave  wb
);

  localparam int AW     = $clog2(`LSU_RAM_WORDS);
  localparam int NLANES = `LSU_XLEN / 8;

  logic [`LSU_XLEN-1:0] mem [0:`LSU_RAM_WORDS-1];
  logic [AW-1:0]        idx;
  logic                 hit;
  logic                 ack_r;
  logic [`LSU_XLEN-1:0] dat_r_q;

  // ram powers up cleared
  initial begin
    for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // doubleword index above the byte offset
  assign idx = wb.adr[3 +: AW];
  assign hit = wb.cyc && wb.stb && !ack_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_r <= 1'b0;
    end else begin
      ack_r <= hit;
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      dat_r_q <= mem[idx];
      for (int b = 0; b < NLANES; b++) begin
        if (wb.we && wb.sel[b]) begin
          mem[idx][8*b +: 8] <= wb.dat_w[8*b +: 8];
        end
      end
    end
  end

  assign wb.ack   = ack_r;
  assign wb.dat_r = dat_r_q;

  // ack only while the master still strobes
  a_ack_with_stb: assert property (
    @(posedge clk) disable iff (rst)
    wb.ack |-> wb.cyc && wb.stb
  );

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module decode_stage import lsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  inst_u      in_inst,
  output logic       in_allowin,
  input  pend_t      ex_pend,
  input  pend_t      mem_pend,
  output reg_addr_t  rs1_addr,
  output reg_addr_t  rs2_addr,
  input  xlen_t      rs1_data,
  input  xlen_t      rs2_data,
  output logic       out_valid,
  output dec_to_ex_t out_bus,
  input  logic       out_allowin
);

  logic        valid;
  inst_u       inst_r;
  logic [6:0]  opcode;
  logic        is_load;
  logic        is_store;
  logic        is_imm;
  logic        hazard;
  logic        ready_go;
  logic [11:0] imm12;

  function automatic logic pend_hit(reg_addr_t r, pend_t p);
    pend_hit = (r != '0) && p.wr && (p.rd == r);
  endfunction

  assign opcode   = inst_r.i.opcode;
  assign is_load  = opcode == `LSU_OP_LOAD;
  assign is_store = opcode == `LSU_OP_STORE;
  assign is_imm   = opcode == `LSU_OP_IMM;

  // rs1 sits at the same bits in both formats
  assign rs1_addr = inst_r.i.rs1;
  assign rs2_addr = inst_r.s.rs2;

  // rs2 is only a real source for stores
  assign hazard = pend_hit(rs1_addr, ex_pend) || pend_hit(rs1_addr, mem_pend) ||
                  (is_store && (pend_hit(rs2_addr, ex_pend) || pend_hit(rs2_addr, mem_pend)));

  assign ready_go   = !hazard;
  assign in_allowin = !valid || (ready_go && out_allowin);
  assign out_valid  = valid && ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (in_allowin) begin
      valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_allowin) begin
      inst_r <= in_inst;
    end
  end

  assign imm12 = is_store ? {inst_r.s.imm_hi, inst_r.s.imm_lo} : inst_r.i.imm;

  always_comb begin
    out_bus.base    = rs1_data;
    out_bus.offset  = {{(`LSU_XLEN-12){imm12[11]}}, imm12};
    out_bus.st_data = rs2_data;
    out_bus.mem_op  = is_load ? MEM_LOAD : (is_store ? MEM_STORE : MEM_NONE);
    out_bus.size    = mem_size_e'(inst_r.i.funct3[1:0]);
    out_bus.uns     = inst_r.i.funct3[2];
    out_bus.rd      = inst_r.i.rd;
    out_bus.wr_ena  = is_load || is_imm;
  end

  // only addi, loads and stores are ever accepted
  a_supported_op: assert property (
    @(posedge clk) disable iff (rst)
    in_valid && in_allowin |=> is_load || is_store || is_imm
  );

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage import lsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  dec_to_ex_t in_bus,
  output logic       in_allowin,
  output logic       out_valid,
  output ex_to_mem_t out_bus,
  input  logic       out_allowin,
  output pend_t      pend
);

  logic       valid;
  dec_to_ex_t bus_r;

  // single-cycle adder that never holds on its own
  assign in_allowin = !valid || out_allowin;
  assign out_valid  = valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (in_allowin) begin
      valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_allowin) begin
      bus_r <= in_bus;
    end
  end

  // addi result or effective address
  always_comb begin
    out_bus.result  = bus_r.base + bus_r.offset;
    out_bus.st_data = bus_r.st_data;
    out_bus.mem_op  = bus_r.mem_op;
    out_bus.size    = bus_r.size;
    out_bus.uns     = bus_r.uns;
    out_bus.rd      = bus_r.rd;
    out_bus.wr_ena  = bus_r.wr_ena;
  end

  assign pend.rd = bus_r.rd;
  assign pend.wr = valid && bus_r.wr_ena;

endmodule

`default_nettype wire

// File: design/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// datapath and register file
`define LSU_XLEN      64
`define LSU_NREGS     32

// data ram depth in doublewords
`define LSU_RAM_WORDS 256

// major opcodes
`define LSU_OP_LOAD   7'b0000011
`define LSU_OP_STORE  7'b0100011
`define LSU_OP_IMM    7'b0010011

`endif

// File: design/lsu_pkg.sv
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

  typedef logic [`LSU_XLEN-1:0] xlen_t;
  typedef logic [4:0]           reg_addr_t;

  // addi and loads
  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // stores
  typedef struct packed {
    logic [6:0]  imm_hi;
    reg_addr_t   rs2;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    logic [4:0]  imm_lo;
    logic [6:0]  opcode;
  } s_fmt_t;

  typedef union packed {
    i_fmt_t i;
    s_fmt_t s;
  } inst_u;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } mem_size_e;

  typedef struct packed {
    reg_addr_t rd;
    logic      wr;
  } pend_t;

  typedef struct packed {
    xlen_t     base;
    xlen_t     offset;
    xlen_t     st_data;
    mem_op_e   mem_op;
    mem_size_e size;
    logic      uns;
    reg_addr_t rd;
    logic      wr_ena;
  } dec_to_ex_t;

  typedef struct packed {
    xlen_t     result;
    xlen_t     st_data;
    mem_op_e   mem_op;
    mem_size_e size;
    logic      uns;
    reg_addr_t rd;
    logic      wr_ena;
  } ex_to_mem_t;

  typedef struct packed {
    reg_addr_t rd;
    logic      wr_ena;
    xlen_t     data;
  } mem_to_wb_t;

endpackage

`default_nettype wire

// File: design/lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      inst_valid,
  input  inst_u     inst,
  output logic      inst_ready,
  output logic      retire_valid,
  output reg_addr_t retire_rd,
  output xlen_t     retire_data
);

  logic       de_valid;
  logic       ex_allowin;
  dec_to_ex_t de_bus;
  logic       ex_valid;
  logic       mem_allowin;
  ex_to_mem_t ex_bus;
  logic       mem_valid;
  logic       wb_allowin;
  mem_to_wb_t mem_bus;
  pend_t      ex_pend;
  pend_t      mem_pend;
  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  xlen_t      rs1_data;
  xlen_t      rs2_data;

  wb_if wb0 ();

  decode_stage u_decode (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (inst_valid),
    .in_inst     (inst),
    .in_allowin  (inst_ready),
    .ex_pend     (ex_pend),
    .mem_pend    (mem_pend),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .out_valid   (de_valid),
    .out_bus     (de_bus),
    .out_allowin (ex_allowin)
  );

  execute_stage u_execute (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (de_valid),
    .in_bus      (de_bus),
    .in_allowin  (ex_allowin),
    .out_valid   (ex_valid),
    .out_bus     (ex_bus),
    .out_allowin (mem_allowin),
    .pend        (ex_pend)
  );

  mem_stage u_mem (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (ex_valid),
    .in_bus      (ex_bus),
    .in_allowin  (mem_allowin),
    .out_valid   (mem_valid),
    .out_bus     (mem_bus),
    .out_allowin (wb_allowin),
    .pend        (mem_pend),
    .wb          (wb0.master)
  );

  data_ram u_ram (
    .clk (clk),
    .rst (rst),
    .wb  (wb0.slave)
  );

  writeback_regfile u_wb (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (mem_valid),
    .in_bus       (mem_bus),
    .in_allowin   (wb_allowin),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

endmodule

`default_nettype wire

// File: design/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module mem_stage import lsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  ex_to_mem_t in_bus,
  output logic       in_allowin,
  output logic       out_valid,
  output mem_to_wb_t out_bus,
  input  logic       out_allowin,
  output pend_t      pend,
  wb_if.master       wb
);

  localparam int XL = `LSU_XLEN;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    REQ  = 2'd1,
    DONE = 2'd2
  } state_e;

  logic       valid;
  ex_to_mem_t bus_r;
  state_e     state;
  xlen_t      load_data;
  logic       is_mem;
  logic       ready_go;
  logic       refresh;
  logic [7:0] size_mask;
  logic [2:0] align_mask;
  xlen_t      lane_data;
  logic [5:0] shamt;
  xlen_t      shifted;
  xlen_t      extended;

  assign is_mem     = bus_r.mem_op != MEM_NONE;
  assign ready_go   = !is_mem || (state == DONE);
  assign in_allowin = !valid || (ready_go && out_allowin);
  assign out_valid  = valid && ready_go;
  assign refresh    = in_valid && in_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      state <= IDLE;
    end else begin
      if (in_allowin) begin
        valid <= in_valid;
      end
      // a memory op starts its request on the entry edge
      if (refresh) begin
        state <= (in_bus.mem_op != MEM_NONE) ? REQ : IDLE;
      end else if (state == REQ && wb.ack) begin
        state <= DONE;
      end else if (state == DONE && out_allowin) begin
        state <= IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (refresh) begin
      bus_r <= in_bus;
    end
    if (state == REQ && wb.ack) begin
      load_data <= extended;
    end
  end

  // lane mask and replicated store data per size
  always_comb begin
    case (bus_r.size)
      SIZE_B: begin
        size_mask  = 8'h01;
        align_mask = 3'b000;
        lane_data  = {(XL/8){bus_r.st_data[7:0]}};
      end
      SIZE_H: begin
        size_mask  = 8'h03;
        align_mask = 3'b001;
        lane_data  = {(XL/16){bus_r.st_data[15:0]}};
      end
      SIZE_W: begin
        size_mask  = 8'h0f;
        align_mask = 3'b011;
        lane_data  = {(XL/32){bus_r.st_data[31:0]}};
      end
      default: begin
        size_mask  = 8'hff;
        align_mask = 3'b111;
        lane_data  = bus_r.st_data;
      end
    endcase
  end

  assign wb.cyc   = state == REQ;
  assign wb.stb   = state == REQ;
  assign wb.we    = bus_r.mem_op == MEM_STORE;
  assign wb.adr   = bus_r.result;
  assign wb.sel   = size_mask << bus_r.result[2:0];
  assign wb.dat_w = lane_data;

  // bring the addressed bytes down to bit 0
  assign shamt   = {bus_r.result[2:0], 3'b000};
  assign shifted = wb.dat_r >> shamt;

  always_comb begin
    case (bus_r.size)
      SIZE_B: extended = {{(XL-8){shifted[7] & !bus_r.uns}}, shifted[7:0]};
      SIZE_H: extended = {{(XL-16){shifted[15] & !bus_r.uns}}, shifted[15:0]};
      SIZE_W: extended = {{(XL-32){shifted[31] & !bus_r.uns}}, shifted[31:0]};
      default: extended = shifted;
    endcase
  end

  assign out_bus.rd     = bus_r.rd;
  assign out_bus.wr_ena = bus_r.wr_ena;
  assign out_bus.data   = (bus_r.mem_op == MEM_LOAD) ? load_data : bus_r.result;

  assign pend.rd = bus_r.rd;
  assign pend.wr = valid && bus_r.wr_ena;

  a_aligned: assert property (
    @(posedge clk) disable iff (rst)
    valid && is_mem |-> (bus_r.result[2:0] & align_mask) == 3'b000
  );

  // request stays up with stb inside cyc until the ack
  a_hold_until_ack: assert property (
    @(posedge clk) disable iff (rst)
    wb.cyc && !wb.ack |=> wb.cyc && wb.stb
  );

endmodule

`default_nettype wire

// File: design/wb_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

interface wb_if;

  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [`LSU_XLEN-1:0] adr;
  logic [7:0]           sel;
  logic [`LSU_XLEN-1:0] dat_w;
  logic [`LSU_XLEN-1:0] dat_r;
  logic                 ack;

  modport master (
    output cyc, stb, we, adr, sel, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, sel, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

// File: design/writeback_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module writeback_regfile import lsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  mem_to_wb_t in_bus,
  output logic       in_allowin,
  input  reg_addr_t  rs1_addr,
  input  reg_addr_t  rs2_addr,
  output xlen_t      rs1_data,
  output xlen_t      rs2_data,
  output logic       retire_valid,
  output reg_addr_t  retire_rd,
  output xlen_t      retire_data
);

  // entry 0 is never written
  xlen_t regs [0:`LSU_NREGS-1];
  logic  wr;

  function automatic xlen_t read_port(reg_addr_t a);
    if (a == '0) begin
      read_port = '0;
    end else if (wr && in_bus.rd == a) begin
      read_port = in_bus.data;
    end else begin
      read_port = regs[a];
    end
  endfunction

  initial begin
    for (int i = 0; i < `LSU_NREGS; i++) begin
      regs[i] = '0;
    end
  end

  assign wr         = in_valid && in_bus.wr_ena && (in_bus.rd != '0);
  assign in_allowin = 1'b1;

  // write-first reads
  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      regs[in_bus.rd] <= in_bus.data;
      retire_rd       <= in_bus.rd;
      retire_data     <= in_bus.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= wr;
    end
  end

endmodule

`default_nettype wire

// File: sim/lsu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module lsu_tb import lsu_pkg::*;;

  typedef enum {ADDI, LB, LH, LW, LD, LBU, LHU, LWU, SB, SH, SW, SD} op_e;

  typedef struct {
    op_e         op;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [11:0] imm;
  } entry_t;

  typedef struct {
    reg_addr_t rd;
    xlen_t     data;
  } retire_t;

  logic      clk;
  logic      rst;
  logic      inst_valid;
  inst_u     inst;
  logic      inst_ready;
  logic      retire_valid;
  reg_addr_t retire_rd;
  xlen_t     retire_data;

  entry_t      stim_q[$];
  retire_t     exp_q[$];
  xlen_t       mregs [0:31];
  logic [7:0]  mmem [0:2047];
  logic [31:0] lcg_state = 32'd63561;

  lsu_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_ready   (inst_ready),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic is_store(op_e op);
    return op inside {SB, SH, SW, SD};
  endfunction

  function automatic int nbytes(op_e op);
    case (op)
      LH, LHU, SH: return 2;
      LW, LWU, SW: return 4;
      LD, SD:      return 8;
      default:     return 1;
    endcase
  endfunction

  function automatic logic [2:0] funct3_of(op_e op);
    case (op)
      LH, SH:  return 3'd1;
      LW, SW:  return 3'd2;
      LD, SD:  return 3'd3;
      LBU:     return 3'd4;
      LHU:     return 3'd5;
      LWU:     return 3'd6;
      default: return 3'd0;
    endcase
  endfunction

  // rv64 encoding with s-type for stores and i-type otherwise
  function automatic inst_u encode(entry_t e);
    inst_u w;
    if (is_store(e.op)) begin
      w.s.imm_hi = e.imm[11:5];
      w.s.rs2    = e.rs2;
      w.s.rs1    = e.rs1;
      w.s.funct3 = funct3_of(e.op);
      w.s.imm_lo = e.imm[4:0];
      w.s.opcode = `LSU_OP_STORE;
    end else begin
      w.i.imm    = e.imm;
      w.i.rs1    = e.rs1;
      w.i.funct3 = funct3_of(e.op);
      w.i.rd     = e.rd;
      w.i.opcode = (e.op == ADDI) ? `LSU_OP_IMM : `LSU_OP_LOAD;
    end
    return w;
  endfunction

  task automatic add(op_e op, int rd, int rs1, int rs2, int imm);
    entry_t e;
    e.op  = op;
    e.rd  = reg_addr_t'(rd);
    e.rs1 = reg_addr_t'(rs1);
    e.rs2 = reg_addr_t'(rs2);
    e.imm = imm[11:0];
    stim_q.push_back(e);
  endtask

  // random accesses in a 128 byte window above x10
  task automatic add_random(int count);
    logic [31:0] r;
    logic [31:0] s;
    op_e         op;
    int          off;
    for (int k = 0; k < count; k++) begin
      r   = lcg_next();
      s   = lcg_next();
      op  = op_e'(int'(r[23:16]) % 12);
      off = int'(s[22:16]) & ~(nbytes(op) - 1);
      if (op == ADDI) begin
        add(ADDI, 11 + int'(r[2:0]) % 5, r[3] ? 11 + int'(r[6:4]) % 5 : 0, 0, int'(s[27:16]));
      end else if (is_store(op)) begin
        add(op, 0, 10, 11 + int'(r[2:0]) % 5, off);
      end else begin
        add(op, 11 + int'(r[2:0]) % 5, 10, 0, off);
      end
    end
  endtask

  // reference model over a little-endian byte memory
  task automatic model_step(entry_t e);
    xlen_t   addr;
    xlen_t   v;
    int      n;
    retire_t ret;
    addr = mregs[e.rs1] + {{52{e.imm[11]}}, e.imm};
    n    = nbytes(e.op);
    v    = '0;
    if (e.op == ADDI) begin
      v = addr;
    end else if (is_store(e.op)) begin
      for (int b = 0; b < n; b++) begin
        mmem[int'(addr[10:0]) + b] = mregs[e.rs2][8*b +: 8];
      end
    end else begin
      for (int b = 0; b < n; b++) begin
        v[8*b +: 8] = mmem[int'(addr[10:0]) + b];
      end
      if ((e.op inside {LB, LH, LW}) && v[8*n-1]) begin
        for (int k = 8 * n; k < 64; k++) begin
          v[k] = 1'b1;
        end
      end
    end
    if (!is_store(e.op) && e.rd != '0) begin
      mregs[e.rd] = v;
      ret.rd      = e.rd;
      ret.data    = v;
      exp_q.push_back(ret);
    end
  endtask

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rd(reg_addr_t got, reg_addr_t want);
    if (got !== want) begin
      $display("ERR %0t retire_rd got %0d expected %0d", $time, got, want);
      stop_run();
    end
  endtask

  task automatic check_data(xlen_t got, xlen_t want);
    if (got !== want) begin
      $display("ERR %0t retire_data got %h expected %h", $time, got, want);
      stop_run();
    end
  endtask

  task automatic check_flag(string name, logic got, logic want);
    if (got !== want) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, want);
      stop_run();
    end
  endtask

  task automatic issue(entry_t e);
    int wait_cnt;
    @(negedge clk);
    inst_valid = 1'b1;
    inst       = encode(e);
    wait_cnt   = 0;
    while (inst_ready !== 1'b1) begin
      @(negedge clk);
      wait_cnt++;
      if (wait_cnt > 50) begin
        $display("timeout: inst_ready stayed low for 50 cycles");
        stop_run();
      end
    end
    model_step(e);
  endtask

  initial begin : monitor
    retire_t want;
    int      idle;
    idle = 0;
    forever begin
      @(negedge clk);
      if (retire_valid === 1'b1) begin
        idle = 0;
        if (exp_q.size() == 0) begin
          $display("unexpected retire of x%0d with no result pending", retire_rd);
          stop_run();
        end else begin
          want = exp_q.pop_front();
          check_rd(retire_rd, want.rd);
          check_data(retire_data, want.data);
        end
      end else if (exp_q.size() != 0) begin
        idle++;
        if (idle > 100) begin
          $display("timeout: no retire for 100 cycles while results are pending");
          stop_run();
        end
      end
    end
  end

  initial begin
    int cnt;
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    for (int i = 0; i < 2048; i++) begin
      mmem[i] = 8'h00;
    end

    // addi with a discarded write to x0
    add(ADDI, 1, 0, 0, -1);
    add(ADDI, 2, 0, 0, 1957);
    add(ADDI, 3, 0, 0, -1756);
    add(ADDI, 4, 2, 0, -2048);
    add(ADDI, 0, 2, 0, 5);
    add(ADDI, 5, 0, 0, 3);
    // doubleword round trips
    add(SD, 0, 0, 3, 64);
    add(LD, 7, 0, 0, 64);
    add(SD, 0, 0, 4, 72);
    add(LD, 8, 0, 0, 72);
    // partial stores then loads at every aligned offset
    add(SB, 0, 0, 2, 65);
    add(SH, 0, 0, 2, 70);
    add(LD, 9, 0, 0, 64);
    for (int o = 0; o < 8; o++) begin
      add(LB, 12, 0, 0, 64 + o);
      add(LBU, 13, 0, 0, 64 + o);
    end
    for (int o = 0; o < 8; o += 2) begin
      add(LH, 12, 0, 0, 64 + o);
      add(LHU, 13, 0, 0, 64 + o);
    end
    for (int o = 0; o < 8; o += 4) begin
      add(LW, 12, 0, 0, 64 + o);
      add(LWU, 13, 0, 0, 64 + o);
    end
    // back-to-back chains through the interlock
    add(ADDI, 6, 0, 0, 128);
    add(SD, 0, 6, 9, 0);
    add(LD, 14, 6, 0, 0);
    add(SD, 0, 0, 14, 136);
    add(LD, 15, 0, 0, 136);
    add(ADDI, 15, 15, 0, 1);
    add(LW, 16, 6, 0, 4);
    add(ADDI, 10, 0, 0, 256);
    add_random(60);

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_flag("inst_ready", inst_ready, 1'b1);
      check_flag("retire_valid", retire_valid, 1'b0);
    end

    foreach (stim_q[i]) begin
      issue(stim_q[i]);
    end
    @(negedge clk);
    inst_valid = 1'b0;

    cnt = 0;
    while (exp_q.size() != 0 && cnt < 200) begin
      @(negedge clk);
      cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d results never retired", exp_q.size());
      stop_run();
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/lsu_pkg.sv
design/wb_if.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_stage.sv
design/data_ram.sv
design/writeback_regfile.sv
design/lsu_top.sv
sim/lsu_tb.sv
